// File: common/isa_pkg.sv
package isa_pkg;

	// Datapath, instruction and PC width
	localparam int XLEN    = 16;
	localparam int REG_AW  = 3;
	localparam int DMEM_AW = 8;
	localparam int OPC_W   = 5;

	// JAL and JALR leave the return address here
	localparam logic [REG_AW-1:0] LINK_REG = 3'd7;

	// Sequential instructions advance by one 16-bit word
	localparam logic [XLEN-1:0] PC_STEP = 16'd2;

	// Instruction field positions
	localparam int OPC_HI    = 15;
	localparam int OPC_LO    = 11;
	localparam int RS_HI     = 10;
	localparam int RS_LO     = 8;
	localparam int RT_HI     = 7;
	localparam int RT_LO     = 5;
	localparam int RD_HI     = 4;
	localparam int RD_LO     = 2;
	localparam int FUNC_HI   = 1;
	localparam int FUNC_LO   = 0;
	localparam int IMM5_HI   = 4;
	localparam int IMM8_HI   = 7;
	localparam int DISP11_HI = 10;

	// Within each group of four the low two bits pick the variant
	typedef enum logic [OPC_W-1:0] {
		HALT    = 5'b00000,
		NOP     = 5'b00001,
		SIIC    = 5'b00010,
		RTI     = 5'b00011,
		J       = 5'b00100,
		JR      = 5'b00101,
		JAL     = 5'b00110,
		JALR    = 5'b00111,
		ADDI    = 5'b01000,
		SUBI    = 5'b01001,
		XORI    = 5'b01010,
		ANDNI   = 5'b01011,
		BEQZ    = 5'b01100,
		BNEZ    = 5'b01101,
		BLTZ    = 5'b01110,
		BGEZ    = 5'b01111,
		ST      = 5'b10000,
		LD      = 5'b10001,
		SLBI    = 5'b10010,
		STU     = 5'b10011,
		ROLI    = 5'b10100,
		SLLI    = 5'b10101,
		RORI    = 5'b10110,
		SRLI    = 5'b10111,
		LBI     = 5'b11000,
		BTR     = 5'b11001,
		ROT_R   = 5'b11010,
		ARITH_R = 5'b11011,
		SEQ     = 5'b11100,
		SLT     = 5'b11101,
		SLE     = 5'b11110,
		SCO     = 5'b11111
	} opcode_e;

endpackage

// File: common/core_pkg.sv
package core_pkg;

	// Groups of four line up with the low two opcode bits
	typedef enum logic [3:0] {
		ADD    = 4'd0,
		SUB    = 4'd1,
		XOR    = 4'd2,
		ANDN   = 4'd3,
		ROL    = 4'd4,
		SLL    = 4'd5,
		ROR    = 4'd6,
		SRL    = 4'd7,
		SEQ    = 4'd8,
		SLT    = 4'd9,
		SLE    = 4'd10,
		SCO    = 4'd11,
		BTR    = 4'd12,
		SLBI   = 4'd13,
		PASS_B = 4'd14
	} alu_op_e;

	typedef enum logic [2:0] {IMM5_S, IMM5_Z, IMM8_S, IMM8_Z, DISP11_S} imm_sel_e;

	typedef enum logic [1:0] {DST_RT, DST_RD, DST_RS, DST_LINK} dst_sel_e;

	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;

	typedef enum logic [2:0] {BR_NONE, BR_EQZ, BR_NEZ, BR_LTZ, BR_GEZ} br_cond_e;

	typedef struct packed {
		alu_op_e  alu_op;
		logic     b_from_imm;
		imm_sel_e imm_sel;
		dst_sel_e dst_sel;
		wb_sel_e  wb_sel;
		logic     reg_write;
		logic     mem_write;
		br_cond_e br_cond;
		logic     jump;
		logic     jump_reg;
		logic     halt;
		logic     err;
	} ctrl_t;

	typedef struct packed {
		logic [isa_pkg::XLEN-1:0]   pc;
		logic [isa_pkg::XLEN-1:0]   next_pc;
		logic                       wb_en;
		logic [isa_pkg::REG_AW-1:0] wb_reg;
		logic [isa_pkg::XLEN-1:0]   wb_data;
		logic                       mem_we;
		logic                       halt;
		logic                       err;
	} retire_t;

endpackage

// File: rtl/control/control.sv
`timescale 1ns/1ps

module control (
	input  isa_pkg::opcode_e i_opcode,
	output core_pkg::ctrl_t  o_ctrl
);

	core_pkg::ctrl_t ctrl;

	assign o_ctrl = ctrl;

	always_comb begin
		ctrl = '0;
		unique case (i_opcode)
			isa_pkg::HALT: begin
				ctrl.halt = 1'b1;
			end
			isa_pkg::NOP: begin
			end
			// No exception support, so these retire flagged and do nothing else
			isa_pkg::SIIC, isa_pkg::RTI: begin
				ctrl.err = 1'b1;
			end
			isa_pkg::J: begin
				ctrl.jump    = 1'b1;
				ctrl.imm_sel = core_pkg::DISP11_S;
			end
			isa_pkg::JAL: begin
				ctrl.jump      = 1'b1;
				ctrl.imm_sel   = core_pkg::DISP11_S;
				ctrl.reg_write = 1'b1;
				ctrl.dst_sel   = core_pkg::DST_LINK;
				ctrl.wb_sel    = core_pkg::WB_LINK;
			end
			// Target is rs + imm, formed by the ALU
			isa_pkg::JR: begin
				ctrl.jump_reg   = 1'b1;
				ctrl.b_from_imm = 1'b1;
				ctrl.imm_sel    = core_pkg::IMM8_S;
			end
			isa_pkg::JALR: begin
				ctrl.jump_reg   = 1'b1;
				ctrl.b_from_imm = 1'b1;
				ctrl.imm_sel    = core_pkg::IMM8_S;
				ctrl.reg_write  = 1'b1;
				ctrl.dst_sel    = core_pkg::DST_LINK;
				ctrl.wb_sel     = core_pkg::WB_LINK;
			end
			isa_pkg::ADDI, isa_pkg::SUBI: begin
				ctrl.alu_op     = core_pkg::alu_op_e'({2'b00, i_opcode[1:0]});
				ctrl.b_from_imm = 1'b1;
				ctrl.imm_sel    = core_pkg::IMM5_S;
				ctrl.reg_write  = 1'b1;
			end
			isa_pkg::XORI, isa_pkg::ANDNI: begin
				ctrl.alu_op     = core_pkg::alu_op_e'({2'b00, i_opcode[1:0]});
				ctrl.b_from_imm = 1'b1;
				ctrl.imm_sel    = core_pkg::IMM5_Z;
				ctrl.reg_write  = 1'b1;
			end
			isa_pkg::ROLI, isa_pkg::SLLI, isa_pkg::RORI, isa_pkg::SRLI: begin
				ctrl.alu_op     = core_pkg::alu_op_e'({2'b01, i_opcode[1:0]});
				ctrl.b_from_imm = 1'b1;
				ctrl.imm_sel    = core_pkg::IMM5_Z;
				ctrl.reg_write  = 1'b1;
			end
			isa_pkg::BEQZ: begin
				ctrl.br_cond = core_pkg::BR_EQZ;
				ctrl.imm_sel = core_pkg::IMM8_S;
			end
			isa_pkg::BNEZ: begin
				ctrl.br_cond = core_pkg::BR_NEZ;
				ctrl.imm_sel = core_pkg::IMM8_S;
			end
			isa_pkg::BLTZ: begin
				ctrl.br_cond = core_pkg::BR_LTZ;
				ctrl.imm_sel = core_pkg::IMM8_S;
			end
			isa_pkg::BGEZ: begin
				ctrl.br_cond = core_pkg::BR_GEZ;
				ctrl.imm_sel = core_pkg::IMM8_S;
			end
			isa_pkg::ST: begin
				ctrl.b_from_imm = 1'b1;
				ctrl.mem_write  = 1'b1;
			end
			isa_pkg::LD: begin
				ctrl.b_from_imm = 1'b1;
				ctrl.reg_write  = 1'b1;
				ctrl.wb_sel     = core_pkg::WB_MEM;
			end
			// Store, then write the effective address back to rs
			isa_pkg::STU: begin
				ctrl.b_from_imm = 1'b1;
				ctrl.mem_write  = 1'b1;
				ctrl.reg_write  = 1'b1;
				ctrl.dst_sel    = core_pkg::DST_RS;
			end
			isa_pkg::LBI, isa_pkg::SLBI: begin
				ctrl.alu_op     = (i_opcode == isa_pkg::LBI) ? core_pkg::PASS_B : core_pkg::SLBI;
				ctrl.b_from_imm = 1'b1;
				ctrl.imm_sel    = (i_opcode == isa_pkg::LBI) ? core_pkg::IMM8_S : core_pkg::IMM8_Z;
				ctrl.reg_write  = 1'b1;
				ctrl.dst_sel    = core_pkg::DST_RS;
			end
			isa_pkg::BTR: begin
				ctrl.alu_op    = core_pkg::BTR;
				ctrl.reg_write = 1'b1;
				ctrl.dst_sel   = core_pkg::DST_RD;
			end
			// Base op of the group; the func field fills in the low bits
			isa_pkg::ROT_R, isa_pkg::ARITH_R: begin
				ctrl.alu_op    = i_opcode[0] ? core_pkg::ADD : core_pkg::ROL;
				ctrl.reg_write = 1'b1;
				ctrl.dst_sel   = core_pkg::DST_RD;
			end
			isa_pkg::SEQ, isa_pkg::SLT, isa_pkg::SLE, isa_pkg::SCO: begin
				ctrl.alu_op    = core_pkg::alu_op_e'({2'b10, i_opcode[1:0]});
				ctrl.reg_write = 1'b1;
				ctrl.dst_sel   = core_pkg::DST_RD;
			end
		endcase
	end

endmodule

// File: rtl/execute/alu.sv
`timescale 1ns/1ps

module alu (
	input  core_pkg::alu_op_e         i_op,
	input  logic [isa_pkg::XLEN-1:0]  i_a,
	input  logic [isa_pkg::XLEN-1:0]  i_b,
	output logic [isa_pkg::XLEN-1:0]  o_result
);

	logic [3:0]                 shamt;
	logic [2*isa_pkg::XLEN-1:0] rol_wide;
	logic [2*isa_pkg::XLEN-1:0] ror_wide;
	logic [isa_pkg::XLEN:0]     sum_wide;
	logic [isa_pkg::XLEN-1:0]   rev;

	assign shamt = i_b[3:0];

	// Rotates shift a doubled copy of a and keep one half
	assign rol_wide = {i_a, i_a} << shamt;
	assign ror_wide = {i_a, i_a} >> shamt;

	assign sum_wide = {1'b0, i_a} + {1'b0, i_b};

	always_comb begin
		for (int i = 0; i < isa_pkg::XLEN; i++) begin
			rev[i] = i_a[isa_pkg::XLEN-1-i];
		end
	end

	always_comb begin
		o_result = '0;
		case (i_op)
			core_pkg::ADD:    o_result = sum_wide[isa_pkg::XLEN-1:0];
			// Subtract is reversed, b minus a
			core_pkg::SUB:    o_result = i_b - i_a;
			core_pkg::XOR:    o_result = i_a ^ i_b;
			core_pkg::ANDN:   o_result = i_a & ~i_b;
			core_pkg::ROL:    o_result = rol_wide[2*isa_pkg::XLEN-1:isa_pkg::XLEN];
			core_pkg::SLL:    o_result = i_a << shamt;
			core_pkg::ROR:    o_result = ror_wide[isa_pkg::XLEN-1:0];
			core_pkg::SRL:    o_result = i_a >> shamt;
			core_pkg::SEQ:    o_result[0] = (i_a == i_b);
			core_pkg::SLT:    o_result[0] = ($signed(i_a) < $signed(i_b));
			core_pkg::SLE:    o_result[0] = ($signed(i_a) <= $signed(i_b));
			core_pkg::SCO:    o_result[0] = sum_wide[isa_pkg::XLEN];
			core_pkg::BTR:    o_result = rev;
			core_pkg::SLBI:   o_result = {i_a[7:0], 8'h00} | i_b;
			core_pkg::PASS_B: o_result = i_b;
			default:          o_result = '0;
		endcase
	end

endmodule

// File: rtl/issue_ctrl.sv
`timescale 1ns/1ps

module issue_ctrl (
	input  logic                       i_clk,
	input  logic                       i_arst_n,
	input  logic                       i_req,
	input  logic [isa_pkg::XLEN-1:0]   i_instr,
	input  core_pkg::ctrl_t            i_ctrl,
	input  logic [isa_pkg::XLEN-1:0]   i_rs_data,
	input  logic [isa_pkg::XLEN-1:0]   i_alu_result,
	input  logic [isa_pkg::XLEN-1:0]   i_mem_rdata,
	output logic                       o_ack,
	output logic                       o_halted,
	output logic [isa_pkg::XLEN-1:0]   o_instr_q,
	output logic                       o_reg_we,
	output logic [isa_pkg::REG_AW-1:0] o_waddr,
	output logic [isa_pkg::XLEN-1:0]   o_wdata,
	output logic                       o_mem_we,
	output core_pkg::retire_t          o_retire
);

	logic [isa_pkg::XLEN-1:0] instr_q;
	logic [isa_pkg::XLEN-1:0] pc_q;
	logic [isa_pkg::XLEN-1:0] pc_plus2;
	logic [isa_pkg::XLEN-1:0] br_off;
	logic [isa_pkg::XLEN-1:0] j_off;
	logic [isa_pkg::XLEN-1:0] next_pc;
	logic                     ack_q;
	logic                     halted_q;
	logic                     exec;
	logic                     wr_ok;
	logic                     br_taken;
	core_pkg::retire_t        retire_q;

	assign exec = i_req && !ack_q && !halted_q;
	assign wr_ok = exec && !i_ctrl.err;

	// Follows the port while no transfer is open and freezes once o_ack is up
	always_ff @(posedge i_clk) begin
		if (!ack_q) begin
			instr_q <= i_instr;
		end
	end
	assign o_instr_q = ack_q ? instr_q : i_instr;

	assign pc_plus2 = pc_q + isa_pkg::PC_STEP;
	assign br_off = {{(isa_pkg::XLEN-isa_pkg::IMM8_HI-1){o_instr_q[isa_pkg::IMM8_HI]}},
		o_instr_q[isa_pkg::IMM8_HI:0]};
	assign j_off = {{(isa_pkg::XLEN-isa_pkg::DISP11_HI-1){o_instr_q[isa_pkg::DISP11_HI]}},
		o_instr_q[isa_pkg::DISP11_HI:0]};

	always_comb begin
		case (i_ctrl.br_cond)
			core_pkg::BR_EQZ: br_taken = (i_rs_data == '0);
			core_pkg::BR_NEZ: br_taken = (i_rs_data != '0);
			core_pkg::BR_LTZ: br_taken = i_rs_data[isa_pkg::XLEN-1];
			core_pkg::BR_GEZ: br_taken = !i_rs_data[isa_pkg::XLEN-1];
			default:          br_taken = 1'b0;
		endcase
	end

	always_comb begin
		if (i_ctrl.jump_reg) begin
			next_pc = i_alu_result;
		end else if (i_ctrl.jump) begin
			next_pc = pc_plus2 + j_off;
		end else if (br_taken) begin
			next_pc = pc_plus2 + br_off;
		end else begin
			next_pc = pc_plus2;
		end
	end

	always_comb begin
		unique case (i_ctrl.dst_sel)
			core_pkg::DST_RT:   o_waddr = o_instr_q[isa_pkg::RT_HI:isa_pkg::RT_LO];
			core_pkg::DST_RD:   o_waddr = o_instr_q[isa_pkg::RD_HI:isa_pkg::RD_LO];
			core_pkg::DST_RS:   o_waddr = o_instr_q[isa_pkg::RS_HI:isa_pkg::RS_LO];
			core_pkg::DST_LINK: o_waddr = isa_pkg::LINK_REG;
		endcase
		case (i_ctrl.wb_sel)
			core_pkg::WB_MEM:  o_wdata = i_mem_rdata;
			core_pkg::WB_LINK: o_wdata = pc_plus2;
			default:           o_wdata = i_alu_result;
		endcase
	end

	assign o_reg_we = wr_ok && i_ctrl.reg_write;
	assign o_mem_we = wr_ok && i_ctrl.mem_write;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pc_q     <= '0;
			ack_q    <= 1'b0;
			halted_q <= 1'b0;
			retire_q <= '0;
		end else if (exec) begin
			ack_q            <= 1'b1;
			pc_q             <= next_pc;
			halted_q         <= i_ctrl.halt;
			retire_q.pc      <= pc_q;
			retire_q.next_pc <= next_pc;
			retire_q.wb_en   <= o_reg_we;
			// Register fields read zero when nothing was written
			retire_q.wb_reg  <= o_reg_we ? o_waddr : '0;
			retire_q.wb_data <= o_reg_we ? o_wdata : '0;
			retire_q.mem_we  <= o_mem_we;
			retire_q.halt    <= i_ctrl.halt;
			retire_q.err     <= i_ctrl.err;
		end else if (!i_req) begin
			ack_q <= 1'b0;
		end
	end

	assign o_ack = ack_q;
	assign o_halted = halted_q;
	assign o_retire = retire_q;

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                       i_clk,
	input  logic                       i_arst_n,
	input  logic                       i_we,
	input  logic [isa_pkg::REG_AW-1:0] i_waddr,
	input  logic [isa_pkg::XLEN-1:0]   i_wdata,
	input  logic [isa_pkg::REG_AW-1:0] i_raddr_a,
	input  logic [isa_pkg::REG_AW-1:0] i_raddr_b,
	output logic [isa_pkg::XLEN-1:0]   o_rdata_a,
	output logic [isa_pkg::XLEN-1:0]   o_rdata_b
);

	logic [isa_pkg::XLEN-1:0] regs [2**isa_pkg::REG_AW];

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < 2**isa_pkg::REG_AW; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we) begin
			regs[i_waddr] <= i_wdata;
		end
	end

	// Reads see the old value during the write cycle
	assign o_rdata_a = regs[i_raddr_a];
	assign o_rdata_b = regs[i_raddr_b];

endmodule

// File: rtl/data_mem.sv
`timescale 1ns/1ps

module data_mem (
	input  logic                        i_clk,
	input  logic                        i_arst_n,
	input  logic                        i_we,
	input  logic [isa_pkg::DMEM_AW-1:0] i_addr,
	input  logic [isa_pkg::XLEN-1:0]    i_wdata,
	output logic [isa_pkg::XLEN-1:0]    o_rdata
);

	logic [isa_pkg::XLEN-1:0] mem [2**isa_pkg::DMEM_AW];

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < 2**isa_pkg::DMEM_AW; i++) begin
				mem[i] <= '0;
			end
		end else if (i_we) begin
			mem[i_addr] <= i_wdata;
		end
	end

	assign o_rdata = mem[i_addr];

endmodule

// File: rtl/wisc_core.sv
`timescale 1ns/1ps

module wisc_core (
	input  logic                     i_clk,
	input  logic                     i_arst_n,
	input  logic                     i_req,
	input  logic [isa_pkg::XLEN-1:0] i_instr,
	output logic                     o_ack,
	output core_pkg::retire_t        o_retire,
	output logic                     o_halted
);

	logic [isa_pkg::XLEN-1:0]   instr_q;
	logic [isa_pkg::XLEN-1:0]   imm_ext;
	logic [isa_pkg::XLEN-1:0]   rs_data;
	logic [isa_pkg::XLEN-1:0]   rt_data;
	logic [isa_pkg::XLEN-1:0]   alu_result;
	logic [isa_pkg::XLEN-1:0]   mem_rdata;
	logic [isa_pkg::XLEN-1:0]   wdata;
	logic [isa_pkg::REG_AW-1:0] waddr;
	logic                       reg_we;
	logic                       mem_we;
	isa_pkg::opcode_e           opcode;
	core_pkg::ctrl_t            ctrl;
	core_pkg::alu_op_e          alu_op;

	assign opcode = isa_pkg::opcode_e'(instr_q[isa_pkg::OPC_HI:isa_pkg::OPC_LO]);

	always_comb begin
		case (ctrl.imm_sel)
			core_pkg::IMM5_S: imm_ext = {{(isa_pkg::XLEN-isa_pkg::IMM5_HI-1){
				instr_q[isa_pkg::IMM5_HI]}}, instr_q[isa_pkg::IMM5_HI:0]};
			core_pkg::IMM5_Z: imm_ext = {{(isa_pkg::XLEN-isa_pkg::IMM5_HI-1){1'b0}},
				instr_q[isa_pkg::IMM5_HI:0]};
			core_pkg::IMM8_S: imm_ext = {{(isa_pkg::XLEN-isa_pkg::IMM8_HI-1){
				instr_q[isa_pkg::IMM8_HI]}}, instr_q[isa_pkg::IMM8_HI:0]};
			core_pkg::IMM8_Z: imm_ext = {{(isa_pkg::XLEN-isa_pkg::IMM8_HI-1){1'b0}},
				instr_q[isa_pkg::IMM8_HI:0]};
			core_pkg::DISP11_S: imm_ext = {{(isa_pkg::XLEN-isa_pkg::DISP11_HI-1){
				instr_q[isa_pkg::DISP11_HI]}}, instr_q[isa_pkg::DISP11_HI:0]};
			default: imm_ext = '0;
		endcase
	end

	// Register ALU groups take their variant from the func field
	always_comb begin
		alu_op = ctrl.alu_op;
		if (opcode == isa_pkg::ROT_R || opcode == isa_pkg::ARITH_R) begin
			alu_op = core_pkg::alu_op_e'({ctrl.alu_op[3:2],
				instr_q[isa_pkg::FUNC_HI:isa_pkg::FUNC_LO]});
		end
	end

	control control_i (.i_opcode(opcode), .o_ctrl(ctrl));

	alu alu_i (
		.i_op(alu_op), .i_a(rs_data),
		.i_b(ctrl.b_from_imm ? imm_ext : rt_data),
		.o_result(alu_result)
	);

	reg_file reg_file_i (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_we(reg_we), .i_waddr(waddr), .i_wdata(wdata),
		.i_raddr_a(instr_q[isa_pkg::RS_HI:isa_pkg::RS_LO]),
		.i_raddr_b(instr_q[isa_pkg::RT_HI:isa_pkg::RT_LO]),
		.o_rdata_a(rs_data), .o_rdata_b(rt_data)
	);

	// Word addressed, so the byte offset bit is dropped
	data_mem data_mem_i (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_we(mem_we),
		.i_addr(alu_result[isa_pkg::DMEM_AW:1]), .i_wdata(rt_data), .o_rdata(mem_rdata)
	);

	issue_ctrl issue_ctrl_i (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_req(i_req), .i_instr(i_instr),
		.i_ctrl(ctrl), .i_rs_data(rs_data), .i_alu_result(alu_result),
		.i_mem_rdata(mem_rdata), .o_ack(o_ack), .o_halted(o_halted), .o_instr_q(instr_q),
		.o_reg_we(reg_we), .o_waddr(waddr), .o_wdata(wdata), .o_mem_we(mem_we),
		.o_retire(o_retire)
	);

endmodule

// File: verification/wisc_core_asserts.sv
`timescale 1ns/1ps

module wisc_core_asserts (
	input logic i_clk,
	input logic i_arst_n,
	input logic i_req,
	input logic i_ack,
	input logic i_halted
);

	// A pending request is taken on the very next edge
	ack_follows_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(i_req && !i_ack && !i_halted) |=> i_ack)
		else $error("o_ack did not rise one edge after i_req");

	ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		$rose(i_ack) |-> $past(i_req))
		else $error("o_ack rose without a request");

	ack_released: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(i_ack && !i_req) |=> !i_ack)
		else $error("o_ack did not fall one edge after i_req dropped");

	// The HALT transfer itself may still complete
	no_ack_when_halted: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_halted |=> !$rose(i_ack))
		else $error("o_ack rose after the core halted");

endmodule

bind wisc_core wisc_core_asserts wisc_core_asserts_i (
	.i_clk(i_clk), .i_arst_n(i_arst_n), .i_req(i_req), .i_ack(o_ack), .i_halted(o_halted)
);

// File: verification/tb_wisc_core.sv
`timescale 1ns/1ps

module tb_wisc_core;

	localparam int CLK_PERIOD = 8;

	typedef struct packed {
		logic [15:0] instr;
		logic        wb_en;
		logic [2:0]  wb_reg;
		logic [15:0] wb_data;
		logic        mem_we;
		logic [15:0] next_pc;
		logic        err;
		logic        halt;
	} vec_t;

	logic              clk = 1'b0;
	logic              arst_n;
	logic              req;
	logic [15:0]       instr;
	logic              ack;
	logic              halted;
	core_pkg::retire_t retire;

	vec_t        vecs[$];
	logic [15:0] exp_pc;

	wisc_core wisc_core_i (
		.i_clk(clk), .i_arst_n(arst_n), .i_req(req), .i_instr(instr),
		.o_ack(ack), .o_retire(retire), .o_halted(halted)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [15:0] enc_i1(input isa_pkg::opcode_e op, input logic [2:0] rs,
		input logic [2:0] rt, input logic [4:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] enc_i2(input isa_pkg::opcode_e op, input logic [2:0] rs,
		input logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	function automatic logic [15:0] enc_r(input isa_pkg::opcode_e op, input logic [2:0] rs,
		input logic [2:0] rt, input logic [2:0] rd, input logic [1:0] func);
		return {op, rs, rt, rd, func};
	endfunction

	function automatic logic [15:0] enc_j(input isa_pkg::opcode_e op, input logic [10:0] disp);
		return {op, disp};
	endfunction

	task automatic expect_wb(input logic [15:0] ins, input logic [2:0] wb_reg,
		input logic [15:0] wb_data, input logic [15:0] next_pc);
		vecs.push_back(vec_t'{ins, 1'b1, wb_reg, wb_data, 1'b0, next_pc, 1'b0, 1'b0});
	endtask

	task automatic expect_nowb(input logic [15:0] ins, input logic [15:0] next_pc,
		input logic err, input logic halt);
		vecs.push_back(vec_t'{ins, 1'b0, 3'd0, 16'd0, 1'b0, next_pc, err, halt});
	endtask

	task automatic expect_store(input logic [15:0] ins, input logic wb_en,
		input logic [2:0] wb_reg, input logic [15:0] wb_data, input logic [15:0] next_pc);
		vecs.push_back(vec_t'{ins, wb_en, wb_reg, wb_data, 1'b1, next_pc, 1'b0, 1'b0});
	endtask

	task automatic check(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			$display("Fail at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("Finished with errors");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// Expected values follow the ISA by hand from PC 0 and cleared registers
	task automatic build_table();
		expect_wb(enc_i2(isa_pkg::LBI, 3'd1, 8'h85), 3'd1, 16'hFF85, 16'h0002);
		expect_wb(enc_i2(isa_pkg::SLBI, 3'd1, 8'h3C), 3'd1, 16'h853C, 16'h0004);
		expect_wb(enc_i2(isa_pkg::LBI, 3'd2, 8'h12), 3'd2, 16'h0012, 16'h0006);
		expect_wb(enc_i1(isa_pkg::ADDI, 3'd2, 3'd3, 5'h1D), 3'd3, 16'h000F, 16'h0008);
		expect_wb(enc_i1(isa_pkg::SUBI, 3'd2, 3'd4, 5'h05), 3'd4, 16'hFFF3, 16'h000A);
		expect_wb(enc_i1(isa_pkg::XORI, 3'd1, 3'd5, 5'h1F), 3'd5, 16'h8523, 16'h000C);
		expect_wb(enc_i1(isa_pkg::ANDNI, 3'd1, 3'd6, 5'h1C), 3'd6, 16'h8520, 16'h000E);
		expect_wb(enc_i1(isa_pkg::ROLI, 3'd1, 3'd3, 5'h04), 3'd3, 16'h53C8, 16'h0010);
		expect_wb(enc_i1(isa_pkg::SLLI, 3'd1, 3'd4, 5'h03), 3'd4, 16'h29E0, 16'h0012);
		expect_wb(enc_i1(isa_pkg::RORI, 3'd1, 3'd5, 5'h08), 3'd5, 16'h3C85, 16'h0014);
		expect_wb(enc_i1(isa_pkg::SRLI, 3'd1, 3'd6, 5'h05), 3'd6, 16'h0429, 16'h0016);
		expect_wb(enc_r(isa_pkg::BTR, 3'd1, 3'd0, 3'd7, 2'd0), 3'd7, 16'h3CA1, 16'h0018);
		expect_wb(enc_r(isa_pkg::ARITH_R, 3'd2, 3'd4, 3'd3, 2'd0), 3'd3, 16'h29F2, 16'h001A);
		expect_wb(enc_r(isa_pkg::ARITH_R, 3'd2, 3'd4, 3'd5, 2'd1), 3'd5, 16'h29CE, 16'h001C);
		expect_wb(enc_r(isa_pkg::ARITH_R, 3'd1, 3'd2, 3'd6, 2'd2), 3'd6, 16'h852E, 16'h001E);
		expect_wb(enc_r(isa_pkg::ARITH_R, 3'd1, 3'd7, 3'd6, 2'd3), 3'd6, 16'h811C, 16'h0020);
		expect_wb(enc_r(isa_pkg::ROT_R, 3'd1, 3'd2, 3'd3, 2'd0), 3'd3, 16'h14F2, 16'h0022);
		expect_wb(enc_r(isa_pkg::ROT_R, 3'd1, 3'd2, 3'd4, 2'd1), 3'd4, 16'h14F0, 16'h0024);
		expect_wb(enc_r(isa_pkg::ROT_R, 3'd1, 3'd2, 3'd5, 2'd2), 3'd5, 16'h214F, 16'h0026);
		expect_wb(enc_r(isa_pkg::ROT_R, 3'd4, 3'd2, 3'd5, 2'd3), 3'd5, 16'h053C, 16'h0028);
		expect_wb(enc_r(isa_pkg::SEQ, 3'd4, 3'd4, 3'd3, 2'd0), 3'd3, 16'h0001, 16'h002A);
		expect_wb(enc_r(isa_pkg::SEQ, 3'd4, 3'd5, 3'd3, 2'd0), 3'd3, 16'h0000, 16'h002C);
		expect_wb(enc_r(isa_pkg::SLT, 3'd1, 3'd2, 3'd6, 2'd0), 3'd6, 16'h0001, 16'h002E);
		expect_wb(enc_r(isa_pkg::SLE, 3'd2, 3'd1, 3'd6, 2'd0), 3'd6, 16'h0000, 16'h0030);
		expect_wb(enc_r(isa_pkg::SLE, 3'd2, 3'd2, 3'd6, 2'd0), 3'd6, 16'h0001, 16'h0032);
		expect_wb(enc_r(isa_pkg::SCO, 3'd1, 3'd1, 3'd4, 2'd0), 3'd4, 16'h0001, 16'h0034);
		expect_wb(enc_r(isa_pkg::SCO, 3'd2, 3'd7, 3'd4, 2'd0), 3'd4, 16'h0000, 16'h0036);
		expect_store(enc_i1(isa_pkg::ST, 3'd2, 3'd1, 5'h04), 1'b0, 3'd0, 16'h0000, 16'h0038);
		expect_wb(enc_i1(isa_pkg::LD, 3'd2, 3'd6, 5'h04), 3'd6, 16'h853C, 16'h003A);
		expect_store(enc_i1(isa_pkg::STU, 3'd5, 3'd7, 5'h1E), 1'b1, 3'd5, 16'h053A, 16'h003C);
		expect_wb(enc_i1(isa_pkg::LD, 3'd5, 3'd3, 5'h00), 3'd3, 16'h3CA1, 16'h003E);
		// Each branch once taken and once not taken
		expect_nowb(enc_i2(isa_pkg::BEQZ, 3'd0, 8'h06), 16'h0046, 1'b0, 1'b0);
		expect_nowb(enc_i2(isa_pkg::BEQZ, 3'd2, 8'h06), 16'h0048, 1'b0, 1'b0);
		expect_nowb(enc_i2(isa_pkg::BNEZ, 3'd2, 8'hFC), 16'h0046, 1'b0, 1'b0);
		expect_nowb(enc_i2(isa_pkg::BNEZ, 3'd0, 8'h10), 16'h0048, 1'b0, 1'b0);
		expect_nowb(enc_i2(isa_pkg::BLTZ, 3'd1, 8'h08), 16'h0052, 1'b0, 1'b0);
		expect_nowb(enc_i2(isa_pkg::BLTZ, 3'd2, 8'h08), 16'h0054, 1'b0, 1'b0);
		expect_nowb(enc_i2(isa_pkg::BGEZ, 3'd2, 8'h20), 16'h0076, 1'b0, 1'b0);
		expect_nowb(enc_i2(isa_pkg::BGEZ, 3'd1, 8'h20), 16'h0078, 1'b0, 1'b0);
		expect_nowb(enc_j(isa_pkg::J, 11'h100), 16'h017A, 1'b0, 1'b0);
		expect_nowb(enc_j(isa_pkg::J, 11'h7D0), 16'h014C, 1'b0, 1'b0);
		expect_wb(enc_j(isa_pkg::JAL, 11'h040), 3'd7, 16'h014E, 16'h018E);
		expect_nowb(enc_i2(isa_pkg::JR, 3'd5, 8'h06), 16'h0540, 1'b0, 1'b0);
		expect_wb(enc_i2(isa_pkg::JALR, 3'd2, 8'hFE), 3'd7, 16'h0542, 16'h0010);
		expect_wb(enc_i2(isa_pkg::JALR, 3'd7, 8'h04), 3'd7, 16'h0012, 16'h0546);
		expect_nowb(enc_i1(isa_pkg::SIIC, 3'd1, 3'd2, 5'h03), 16'h0548, 1'b1, 1'b0);
		expect_nowb(enc_i1(isa_pkg::RTI, 3'd3, 3'd4, 5'h00), 16'h054A, 1'b1, 1'b0);
		expect_nowb(enc_j(isa_pkg::NOP, 11'h000), 16'h054C, 1'b0, 1'b0);
		expect_wb(enc_i2(isa_pkg::LBI, 3'd4, 8'h7F), 3'd4, 16'h007F, 16'h054E);
		expect_nowb(enc_j(isa_pkg::HALT, 11'h000), 16'h0550, 1'b0, 1'b1);
	endtask

	// One four-phase transfer with a random idle gap and a random request hold
	task automatic run_vector(input vec_t v);
		int gap;
		int hold;
		int edges;
		gap = $urandom % 4;
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
		instr = v.instr;
		req = 1'b1;
		edges = 0;
		while (!ack) begin
			@(posedge clk);
			#1;
			edges++;
		end
		check("ack latency", 64'(edges), 64'd1);
		check("o_retire.pc", 64'(retire.pc), 64'(exp_pc));
		check("o_retire.next_pc", 64'(retire.next_pc), 64'(v.next_pc));
		check("o_retire.wb_en", 64'(retire.wb_en), 64'(v.wb_en));
		check("o_retire.wb_reg", 64'(retire.wb_reg), 64'(v.wb_reg));
		check("o_retire.wb_data", 64'(retire.wb_data), 64'(v.wb_data));
		check("o_retire.mem_we", 64'(retire.mem_we), 64'(v.mem_we));
		check("o_retire.err", 64'(retire.err), 64'(v.err));
		check("o_retire.halt", 64'(retire.halt), 64'(v.halt));
		exp_pc = v.next_pc;
		hold = $urandom % 6;
		repeat (hold) begin
			@(posedge clk);
			#1;
			check("o_ack while held", 64'(ack), 64'd1);
		end
		req = 1'b0;
		instr = 16'($urandom);
		edges = 0;
		while (ack) begin
			@(posedge clk);
			#1;
			edges++;
		end
		check("ack release latency", 64'(edges), 64'd1);
	endtask

	initial begin
		#1;
		#((vecs.size() + 4) * 20 * CLK_PERIOD);
		$display("Timeout: the instruction handshake stalled before all vectors retired");
		$display("Finished with errors");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		void'($urandom(32'h211df1ec));
		arst_n = 1'b0;
		req = 1'b0;
		instr = '0;
		build_table();
		exp_pc = '0;
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(posedge clk);
		#1;
		check("o_ack", 64'(ack), 64'd0);
		check("o_halted", 64'(halted), 64'd0);
		check("o_retire", 64'(retire), 64'd0);
		foreach (vecs[i]) begin
			run_vector(vecs[i]);
		end
		check("o_halted", 64'(halted), 64'd1);
		// A halted core must ignore any further request
		instr = enc_i2(isa_pkg::LBI, 3'd1, 8'h55);
		req = 1'b1;
		repeat (10) begin
			@(posedge clk);
			#1;
			check("o_ack after halt", 64'(ack), 64'd0);
		end
		check("o_retire.pc after halt", 64'(retire.pc), 64'h054E);
		req = 1'b0;
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: vlog.f
common/isa_pkg.sv
common/core_pkg.sv
rtl/control/control.sv
rtl/execute/alu.sv
rtl/issue_ctrl.sv
rtl/reg_file.sv
rtl/data_mem.sv
rtl/wisc_core.sv
verification/wisc_core_asserts.sv
verification/tb_wisc_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_wisc_core -f vlog.f

./obj_dir/Vtb_wisc_core 2>&1 | tee "$LOG"

if grep -qx "Finished with errors" "$LOG"; then
	echo "Simulation failed"
	exit 1
fi

if ! grep -qx "Finished with no errors" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi

echo "Simulation passed"
